// File: sfp_mgmt_config.svh
/*
   sizing macros for the sfp management plane
*/
`ifndef SFP_MGMT_CONFIG_SVH
`define SFP_MGMT_CONFIG_SVH

// number of sfp+ cages behind the bus
`define SFP_NUM_PORTS 4

// wishbone classic widths
// adr[7:4] port, adr[3:2] register
`define SFP_ADR_W 8
`define SFP_DAT_W 32

// raw phy status word per port
// 10GbE core status / 1GbE status vector
`define SFP_PHY_W 16

`endif

// File: sfp_mgmt_pkg.sv
/*
   shared types: protocol select, register index, phy status union
*/
`default_nettype none

`include "sfp_mgmt_config.svh"

package sfp_mgmt_pkg;

   // per-port protocol, ctrl bit 1
   typedef enum logic {
      SFP_PROTO_10G = 1'b0,
      SFP_PROTO_1G  = 1'b1
   } sfp_proto_e;

   // register slot inside one port, adr[3:2]
   typedef enum logic [1:0] {
      SFP_REG_CTRL   = 2'd0,
      SFP_REG_STATUS = 2'd1,
      SFP_REG_EVENT  = 2'd2,
      SFP_REG_RSVD   = 2'd3
   } sfp_reg_e;

   // ---------------------------------------------------------
   // phy status word, two readings of the same 16 bits
   // ---------------------------------------------------------
   typedef union packed {
      // 10GbE pcs core status
      struct packed {
         logic [`SFP_PHY_W-3:0] spare;
         logic                  hi_ber;
         logic                  pcs_block_lock;
      } ten_g;
      // 1GbE pcs/pma status vector
      struct packed {
         logic [`SFP_PHY_W-3:0] spare;
         logic                  link_sync;
         logic                  link_status;
      } one_g;
   } sfp_phy_status_u;

endpackage

`default_nettype wire

// File: sfp_port_bus_if.sv
/*
   reduced register access path from the decoder to one port core
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

interface sfp_port_bus_if
   import sfp_mgmt_pkg::*;
();

   // request, held while the wishbone access is pending
   logic                  stb;
   logic                  we;
   sfp_reg_e              reg_sel;
   logic [`SFP_DAT_W-1:0] wdat;

   // response, single-cycle ack with data alongside
   logic [`SFP_DAT_W-1:0] rdat;
   logic                  ack;

   modport decoder (output stb, we, reg_sel, wdat);

   modport port (input stb, we, reg_sel, wdat, output rdat, ack);

   // collector only watches the response side
   modport monitor (input rdat, ack);

endinterface

`default_nettype wire

// File: sfp_wb_decoder.sv
/*
   wishbone classic slave front end
   port and register select, local ack for unpopulated ports
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

module sfp_wb_decoder
   import sfp_mgmt_pkg::*;
(
   input  wire                  bus_clk_i,
   input  wire                  arst_n_i,

   input  wire                  wb_cyc_i,
   input  wire                  wb_stb_i,
   input  wire                  wb_we_i,
   input  wire [`SFP_ADR_W-1:0] wb_adr_i,
   input  wire [`SFP_DAT_W-1:0] wb_dat_i,

   sfp_port_bus_if.decoder      bus [`SFP_NUM_PORTS-1:0],

   output logic                 out_of_range_o
);

   // port field is everything above the register field
   localparam int PORT_W = `SFP_ADR_W - 4;

   logic              req;
   logic [PORT_W-1:0] port_idx;
   sfp_reg_e          reg_idx;
   logic              in_range;

   // valid cycle of a classic access
   assign req      = wb_cyc_i & wb_stb_i;

   // adr[1:0] is byte lane, not decoded
   assign port_idx = wb_adr_i[`SFP_ADR_W-1:4];
   assign reg_idx  = sfp_reg_e'(wb_adr_i[3:2]);
   assign in_range = int'(port_idx) < `SFP_NUM_PORTS;

   // ---------------------------------------------------------
   // fan out to the port cores
   // ---------------------------------------------------------
   for (genvar i = 0; i < `SFP_NUM_PORTS; i++) begin : g_port
      // only the addressed port sees stb
      assign bus[i].stb     = req & (port_idx == PORT_W'(i));
      assign bus[i].we      = wb_we_i;
      assign bus[i].reg_sel = reg_idx;
      assign bus[i].wdat    = wb_dat_i;
   end

   // ---------------------------------------------------------
   // empty slot in the port space
   // ---------------------------------------------------------
   // same timing as a port core ack, one per strobe
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_of_range_o <= 1'b0;
      end else begin
         out_of_range_o <= req & ~in_range & ~out_of_range_o;
      end
   end

endmodule

`default_nettype wire

// File: sfp_port_regs.sv
/*
   one cage: ctrl, status, event registers, pin synchronizers, irq
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

module sfp_port_regs
   import sfp_mgmt_pkg::*;
#(
   parameter int PORT_ID = 0
)(
   input  wire             bus_clk_i,
   input  wire             arst_n_i,

   sfp_port_bus_if.port    bus,

   input  wire             sfp_rxlos_i,
   input  wire             sfp_tx_fault_i,
   input  sfp_phy_status_u phy_status_i,

   output logic            sfp_tx_disable_o,
   output logic            irq_o
);

   // ctrl fields
   logic       tx_disable_q;
   sfp_proto_e proto_q;
   logic       irq_en_q;

   // cage pin synchronizers
   logic       rxlos_meta;
   logic       rxlos_sync;
   logic       tx_fault_meta;
   logic       tx_fault_sync;

   // previous values for edge detect
   logic       rxlos_prev;
   logic       tx_fault_prev;
   logic       link_prev;

   logic       link_up;
   logic [1:0] warmup_q;
   logic       armed;
   logic [2:0] event_q;
   logic [2:0] event_set;
   logic [2:0] event_clr;
   logic       ack_q;
   logic       wr_hit;

   // ---------------------------------------------------------
   // access handshake
   // ---------------------------------------------------------
   // one ack per strobe, blank cycle after each ack
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus.stb & ~ack_q;
      end
   end

   assign bus.ack = ack_q;

   // write lands on the edge that raises ack
   assign wr_hit  = bus.stb & bus.we & ~ack_q;

   // ctrl, laser off until software says otherwise
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_disable_q <= 1'b1;
         proto_q      <= SFP_PROTO_10G;
         irq_en_q     <= 1'b0;
      end else if (wr_hit && bus.reg_sel == SFP_REG_CTRL) begin
         tx_disable_q <= bus.wdat[0];
         proto_q      <= sfp_proto_e'(bus.wdat[1]);
         irq_en_q     <= bus.wdat[2];
      end
   end

   // ---------------------------------------------------------
   // pins and link state
   // ---------------------------------------------------------
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxlos_meta    <= 1'b0;
         rxlos_sync    <= 1'b0;
         tx_fault_meta <= 1'b0;
         tx_fault_sync <= 1'b0;
      end else begin
         rxlos_meta    <= sfp_rxlos_i;
         rxlos_sync    <= rxlos_meta;
         tx_fault_meta <= sfp_tx_fault_i;
         tx_fault_sync <= tx_fault_meta;
      end
   end

   // 10GbE: block lock without high ber
   // 1GbE: link status and sync both up
   always_comb begin
      if (proto_q == SFP_PROTO_1G) begin
         link_up = phy_status_i.one_g.link_status & phy_status_i.one_g.link_sync;
      end else begin
         link_up = phy_status_i.ten_g.pcs_block_lock & ~phy_status_i.ten_g.hi_ber;
      end
   end

   // hold off edge detect until the sync chain has filled
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         warmup_q      <= 2'd0;
         rxlos_prev    <= 1'b0;
         tx_fault_prev <= 1'b0;
         link_prev     <= 1'b0;
      end else begin
         if (!armed) begin
            warmup_q <= warmup_q + 2'd1;
         end
         rxlos_prev    <= rxlos_sync;
         tx_fault_prev <= tx_fault_sync;
         link_prev     <= link_up;
      end
   end

   assign armed = (warmup_q == 2'd3);

   // ---------------------------------------------------------
   // events, write one to clear
   // ---------------------------------------------------------
   // bit 0 rxlos either edge, bit 1 tx_fault rising, bit 2 link either edge
   assign event_set = {link_up ^ link_prev,
                       tx_fault_sync & ~tx_fault_prev,
                       rxlos_sync ^ rxlos_prev} & {3{armed}};

   assign event_clr = (wr_hit && bus.reg_sel == SFP_REG_EVENT) ? bus.wdat[2:0] : 3'b000;

   // a new edge wins over a clear in the same cycle
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         event_q <= 3'b000;
      end else begin
         event_q <= (event_q & ~event_clr) | event_set;
      end
   end

   assign irq_o            = irq_en_q & (|event_q);
   assign sfp_tx_disable_o = tx_disable_q;

   // ---------------------------------------------------------
   // readback
   // ---------------------------------------------------------
   always_comb begin
      bus.rdat = '0;
      case (bus.reg_sel)
         SFP_REG_CTRL: begin
            bus.rdat[0] = tx_disable_q;
            bus.rdat[1] = proto_q;
            bus.rdat[2] = irq_en_q;
         end
         SFP_REG_STATUS: begin
            bus.rdat[0] = rxlos_sync;
            bus.rdat[1] = tx_fault_sync;
            bus.rdat[2] = link_up;
            // raw word in the top half
            bus.rdat[`SFP_DAT_W-1 -: `SFP_PHY_W] = phy_status_i;
         end
         SFP_REG_EVENT: begin
            bus.rdat[2:0] = event_q;
         end
         default: begin
            // rsvd reads zero
            bus.rdat = '0;
         end
      endcase
   end

   // blank cycle covers one held cycle only, strobe must be gone after its ack
   a_single_ack: assert property (@(posedge bus_clk_i) disable iff (!arst_n_i)
      bus.ack |=> !bus.stb)
      else $error("port %0d strobe still high after its ack", PORT_ID);

endmodule

`default_nettype wire

// File: sfp_irq_collect.sv
/*
   response return path: ack or, read data mux, registered interrupt
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

module sfp_irq_collect (
   input  wire                   bus_clk_i,
   input  wire                   arst_n_i,

   sfp_port_bus_if.monitor       bus [`SFP_NUM_PORTS-1:0],
   input  wire [`SFP_NUM_PORTS-1:0] irq_i,
   input  wire                   out_of_range_i,

   output logic                  wb_ack_o,
   output logic [`SFP_DAT_W-1:0] wb_dat_o,
   output logic                  wb_int_o
);

   logic [`SFP_NUM_PORTS-1:0] ack_vec;
   logic [`SFP_DAT_W-1:0]     rdat_arr [`SFP_NUM_PORTS];

   // flatten the interface array for indexed access
   for (genvar i = 0; i < `SFP_NUM_PORTS; i++) begin : g_gather
      assign ack_vec[i]  = bus[i].ack;
      assign rdat_arr[i] = bus[i].rdat;
   end

   // ---------------------------------------------------------
   // bus response
   // ---------------------------------------------------------
   assign wb_ack_o = (|ack_vec) | out_of_range_i;

   // and-or mux on ack, empty slot falls through as zero
   always_comb begin
      wb_dat_o = '0;
      for (int i = 0; i < `SFP_NUM_PORTS; i++) begin
         if (ack_vec[i]) begin
            wb_dat_o = wb_dat_o | rdat_arr[i];
         end
      end
   end

   // ---------------------------------------------------------
   // interrupt
   // ---------------------------------------------------------
   // level irq, one cycle behind the enabled event
   always_ff @(posedge bus_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_int_o <= 1'b0;
      end else begin
         wb_int_o <= |irq_i;
      end
   end

   // decoder strobes one target, so responses never collide
   a_one_responder: assert property (@(posedge bus_clk_i) disable iff (!arst_n_i)
      $onehot0({ack_vec, out_of_range_i}))
      else $error("more than one ack on the return path");

endmodule

`default_nettype wire

// File: sfp_mgmt_top.sv
/*
   sfp+ management plane top: decoder, port cores, collector
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

module sfp_mgmt_top
   import sfp_mgmt_pkg::*;
(
   input  wire                                bus_clk_i,
   input  wire                                arst_n_i,

   // wishbone classic slave
   input  wire                                wb_cyc_i,
   input  wire                                wb_stb_i,
   input  wire                                wb_we_i,
   input  wire [`SFP_ADR_W-1:0]               wb_adr_i,
   input  wire [`SFP_DAT_W-1:0]               wb_dat_i,
   output wire                                wb_ack_o,
   output wire [`SFP_DAT_W-1:0]               wb_dat_o,
   output wire                                wb_int_o,

   // cage pins and phy status, one lane per port
   input  wire [`SFP_NUM_PORTS-1:0]           sfp_rxlos_i,
   input  wire [`SFP_NUM_PORTS-1:0]           sfp_tx_fault_i,
   input  wire [`SFP_NUM_PORTS*`SFP_PHY_W-1:0] phy_status_i,
   output wire [`SFP_NUM_PORTS-1:0]           sfp_tx_disable_o
);

   wire [`SFP_NUM_PORTS-1:0] port_irq;
   wire                      out_of_range;

   sfp_port_bus_if port_bus [`SFP_NUM_PORTS-1:0] ();

   sfp_wb_decoder u_decoder (
      .bus_clk_i      (bus_clk_i),
      .arst_n_i       (arst_n_i),
      .wb_cyc_i       (wb_cyc_i),
      .wb_stb_i       (wb_stb_i),
      .wb_we_i        (wb_we_i),
      .wb_adr_i       (wb_adr_i),
      .wb_dat_i       (wb_dat_i),
      .bus            (port_bus),
      .out_of_range_o (out_of_range)
   );

   // ---------------------------------------------------------
   // one register core per cage
   // ---------------------------------------------------------
   for (genvar i = 0; i < `SFP_NUM_PORTS; i++) begin : g_port
      sfp_port_regs #(
         .PORT_ID (i)
      ) u_port (
         .bus_clk_i        (bus_clk_i),
         .arst_n_i         (arst_n_i),
         .bus              (port_bus[i]),
         .sfp_rxlos_i      (sfp_rxlos_i[i]),
         .sfp_tx_fault_i   (sfp_tx_fault_i[i]),
         .phy_status_i     (sfp_phy_status_u'(phy_status_i[i*`SFP_PHY_W +: `SFP_PHY_W])),
         .sfp_tx_disable_o (sfp_tx_disable_o[i]),
         .irq_o            (port_irq[i])
      );
   end

   sfp_irq_collect u_collect (
      .bus_clk_i      (bus_clk_i),
      .arst_n_i       (arst_n_i),
      .bus            (port_bus),
      .irq_i          (port_irq),
      .out_of_range_i (out_of_range),
      .wb_ack_o       (wb_ack_o),
      .wb_dat_o       (wb_dat_o),
      .wb_int_o       (wb_int_o)
   );

endmodule

`default_nettype wire

// File: tb_sfp_mgmt.sv
/*
   table-driven testbench for the sfp+ management plane
   wishbone access task, status model, watchdog
*/
`timescale 1ns/1ps
`default_nettype none

`include "sfp_mgmt_config.svh"

module tb_sfp_mgmt
   import sfp_mgmt_pkg::*;
();

   localparam int NUM_PORTS = `SFP_NUM_PORTS;
   localparam int PHY_W     = `SFP_PHY_W;

   // step kinds
   localparam logic [2:0] K_WR   = 3'd0;
   localparam logic [2:0] K_RD   = 3'd1;
   localparam logic [2:0] K_PIN  = 3'd2;
   localparam logic [2:0] K_WAIT = 3'd3;
   localparam logic [2:0] K_STAT = 3'd4;
   localparam logic [2:0] K_TXD  = 3'd5;
   localparam logic [2:0] K_INT  = 3'd6;

   typedef struct packed {
      logic [2:0]  kind;
      logic [3:0]  port;
      logic [1:0]  rsel;
      logic [31:0] data;
      logic [31:0] exp;
   } step_t;

   logic                          clk;
   logic                          arst_n;
   logic                          wb_cyc;
   logic                          wb_stb;
   logic                          wb_we;
   logic [`SFP_ADR_W-1:0]         wb_adr;
   logic [`SFP_DAT_W-1:0]         wb_dat_w;
   wire                           wb_ack;
   wire  [`SFP_DAT_W-1:0]         wb_dat_r;
   wire                           wb_int;
   logic [NUM_PORTS-1:0]          sfp_rxlos;
   logic [NUM_PORTS-1:0]          sfp_tx_fault;
   logic [NUM_PORTS*PHY_W-1:0]    phy_status;
   wire  [NUM_PORTS-1:0]          sfp_tx_disable;

   // ctrl bits as software last wrote them, 3 per port
   logic [3*NUM_PORTS-1:0]        ctrl_m;
   step_t                         steps[$];
   logic                          table_ready;
   int                            errors;
   int                            checks;

   sfp_mgmt_top dut (
      .bus_clk_i        (clk),
      .arst_n_i         (arst_n),
      .wb_cyc_i         (wb_cyc),
      .wb_stb_i         (wb_stb),
      .wb_we_i          (wb_we),
      .wb_adr_i         (wb_adr),
      .wb_dat_i         (wb_dat_w),
      .wb_ack_o         (wb_ack),
      .wb_dat_o         (wb_dat_r),
      .wb_int_o         (wb_int),
      .sfp_rxlos_i      (sfp_rxlos),
      .sfp_tx_fault_i   (sfp_tx_fault),
      .phy_status_i     (phy_status),
      .sfp_tx_disable_o (sfp_tx_disable)
   );

   // 8 ns bus clock
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic add_step(input logic [2:0] kind, input int port, input logic [1:0] rsel,
                           input logic [31:0] data, input logic [31:0] exp);
      step_t s;
      s.kind = kind;
      s.port = port[3:0];
      s.rsel = rsel;
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
   endtask

   // expected STATUS word from pins, phy word and the modelled proto bit
   function automatic logic [31:0] status_expect(input int p);
      logic [15:0] w;
      logic        link;
      w = phy_status[p*PHY_W +: PHY_W];
      if (ctrl_m[p*3+1]) begin
         // 1GbE, status and sync
         link = w[0] & w[1];
      end else begin
         // 10GbE, block lock and no hi_ber
         link = w[0] & ~w[1];
      end
      return {w, 13'd0, link, sfp_tx_fault[p], sfp_rxlos[p]};
   endfunction

   // one wishbone classic cycle, checks the single ack
   task automatic wb_access(input logic we, input logic [3:0] port, input logic [1:0] rsel,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int waited;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= {port, rsel, 2'b00};
      wb_dat_w <= wdat;
      @(negedge clk);
      checks++;
      assert (!wb_ack) else begin
         errors++;
         $display("error %0t: ack in the same cycle as the strobe", $time);
      end
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < 16);
      checks++;
      assert (wb_ack) else begin
         errors++;
         $display("no ack came back for port %0d register %0d", port, rsel);
      end
      checks++;
      assert (waited == 1) else begin
         errors++;
         $display("error %0t: ack after %0d cycles, expected 1", $time, waited);
      end
      rdat = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(negedge clk);
      checks++;
      assert (!wb_ack) else begin
         errors++;
         $display("error %0t: second ack cycle for one access", $time);
      end
   endtask

   // ------------------------------------------------------------
   // stimulus table
   // ------------------------------------------------------------
   // pin data: bit 0 rxlos, bit 1 tx_fault, bit 2 new phy word,
   // bit 3 phy bit 0, bit 4 phy bit 1
   task automatic build_table();
      // reset state
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_RD, p, SFP_REG_CTRL, 0, 1);
      add_step(K_TXD, 0, 0, 0, 32'hf);
      add_step(K_INT, 0, 0, 0, 0);
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_RD, p, SFP_REG_EVENT, 0, 0);
      // control path, each laser pin follows its own port
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_WR, p, SFP_REG_CTRL, p, 0);
      add_step(K_TXD, 0, 0, 0, 32'b1010);
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_RD, p, SFP_REG_CTRL, 0, p);
      add_step(K_WR, 1, SFP_REG_CTRL, 0, 0);
      add_step(K_TXD, 0, 0, 0, 32'b1000);
      // status and both union views
      add_step(K_PIN, 0, 0, 32'h0d, 0);
      add_step(K_PIN, 1, 0, 32'h1e, 0);
      add_step(K_PIN, 2, 0, 32'h1f, 0);
      add_step(K_PIN, 3, 0, 32'h0c, 0);
      add_step(K_WAIT, 0, 0, 4, 0);
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_STAT, p, SFP_REG_STATUS, 0, 0);
      add_step(K_WR, 0, SFP_REG_CTRL, 2, 0);
      add_step(K_WR, 1, SFP_REG_CTRL, 2, 0);
      add_step(K_WR, 2, SFP_REG_CTRL, 0, 0);
      add_step(K_WR, 3, SFP_REG_CTRL, 1, 0);
      for (int p = 0; p < NUM_PORTS; p++) add_step(K_STAT, p, SFP_REG_STATUS, 0, 0);
      // events, port 0 with irq_en
      add_step(K_WR, 0, SFP_REG_EVENT, 7, 0);
      add_step(K_WR, 1, SFP_REG_EVENT, 7, 0);
      add_step(K_RD, 0, SFP_REG_EVENT, 0, 0);
      add_step(K_WR, 0, SFP_REG_CTRL, 6, 0);
      add_step(K_INT, 0, 0, 0, 0);
      add_step(K_PIN, 0, 0, 32'h00, 0);
      add_step(K_INT, 0, 0, 0, 1);
      add_step(K_RD, 0, SFP_REG_EVENT, 0, 1);
      add_step(K_WR, 0, SFP_REG_EVENT, 1, 0);
      add_step(K_INT, 0, 0, 0, 0);
      add_step(K_RD, 0, SFP_REG_EVENT, 0, 0);
      // port 1 latches without interrupt
      add_step(K_PIN, 1, 0, 32'h03, 0);
      add_step(K_WAIT, 0, 0, 6, 0);
      add_step(K_RD, 1, SFP_REG_EVENT, 0, 1);
      add_step(K_INT, 0, 0, 0, 0);
      // rsvd slot and empty ports
      add_step(K_WR, 2, SFP_REG_RSVD, 32'hffff_ffff, 0);
      add_step(K_RD, 2, SFP_REG_RSVD, 0, 0);
      add_step(K_RD, 4, SFP_REG_CTRL, 0, 0);
      add_step(K_RD, 15, SFP_REG_STATUS, 0, 0);
      add_step(K_WR, 4, SFP_REG_CTRL, 1, 0);
      add_step(K_TXD, 0, 0, 0, 32'b1000);
      add_step(K_RD, 3, SFP_REG_CTRL, 0, 1);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      step_t       s;
      int          p;
      int          waited;
      logic [31:0] rd;
      logic [31:0] exp_v;
      logic [31:0] rnd;
      void'($urandom(11));
      arst_n       = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      // empty cages hold loss of signal through reset
      sfp_rxlos    = '1;
      sfp_tx_fault = '0;
      phy_status   = '0;
      errors       = 0;
      checks       = 0;
      table_ready  = 1'b0;
      // reset value of every ctrl: laser off, 10GbE, irq off
      for (int i = 0; i < NUM_PORTS; i++) ctrl_m[i*3 +: 3] = 3'b001;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) @(posedge clk);

      foreach (steps[i]) begin
         s = steps[i];
         p = int'(s.port);
         case (s.kind)
            K_WR: begin
               wb_access(1'b1, s.port, s.rsel, s.data, rd);
               if (p < NUM_PORTS && s.rsel == SFP_REG_CTRL) begin
                  ctrl_m[p*3 +: 3] = s.data[2:0];
               end
            end
            K_RD, K_STAT: begin
               wb_access(1'b0, s.port, s.rsel, 32'd0, rd);
               exp_v = (s.kind == K_STAT) ? status_expect(p) : s.exp;
               checks++;
               assert (rd == exp_v) else begin
                  errors++;
                  $display("error %0t: port %0d reg %0d read %h, expected %h",
                           $time, p, s.rsel, rd, exp_v);
               end
            end
            K_PIN: begin
               @(posedge clk);
               sfp_rxlos[p]    <= s.data[0];
               sfp_tx_fault[p] <= s.data[1];
               if (s.data[2]) begin
                  rnd = $urandom;
                  phy_status[p*PHY_W +: PHY_W] <= {rnd[15:2], s.data[4], s.data[3]};
               end
            end
            K_WAIT: begin
               repeat (s.data) @(posedge clk);
            end
            K_TXD: begin
               @(negedge clk);
               checks++;
               assert (sfp_tx_disable == s.exp[NUM_PORTS-1:0]) else begin
                  errors++;
                  $display("error %0t: tx_disable %b, expected %b",
                           $time, sfp_tx_disable, s.exp[NUM_PORTS-1:0]);
               end
            end
            default: begin
               // interrupt level, allowed to settle for a few cycles
               waited = 0;
               @(negedge clk);
               while (wb_int != s.exp[0] && waited < 8) begin
                  @(negedge clk);
                  waited++;
               end
               checks++;
               assert (wb_int == s.exp[0]) else begin
                  errors++;
                  $display("error %0t: wb_int_o is %b, expected %b", $time, wb_int, s.exp[0]);
               end
            end
         endcase
      end

      repeat (4) @(posedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog, 20 cycles per table step on top of reset
   initial begin
      wait (table_ready);
      repeat (steps.size() * 20 + 16) @(posedge clk);
      $display("watchdog expired before the table finished, errors so far: %0d", errors);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
sfp_mgmt_pkg.sv
sfp_port_bus_if.sv
sfp_wb_decoder.sv
sfp_port_regs.sv
sfp_irq_collect.sv
sfp_mgmt_top.sv
tb_sfp_mgmt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sfp management testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sfp_mgmt -f vlog.f -o tb_sfp_mgmt \
   > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sfp_mgmt > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation PASSED"
